// ==== hw/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECTL        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ESTAT_IS        12:0
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22
// split of the interrupt status vector
`define IS_SW           1:0
`define IS_HW           9:2
`define IS_TI           11
`define ECTL_LIE        12:0
`define ECTL_LIE_WMASK  13'h0bff
`define EENTRY_VA       31:6
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

// direct address mode out of reset
`define CRMD_RESET      32'h0000_0008
`define SAVE_COUNT      4
`define TIMER_SHIFT     2

`endif

// ==== hw/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // one csr data word
    typedef logic [31:0] csr_word_t;

    // csr number as carried by csrrd/csrwr
    typedef logic [13:0] csr_addr_t;

    typedef logic [1:0] plv_t;

    typedef logic [5:0] ecode_t;

    typedef logic [8:0] esubcode_t;

    // estat.is layout
    // 1:0 software, 9:2 hardware lines, 11 timer, 10 and 12 reserved
    typedef logic [12:0] int_vec_t;

endpackage

`default_nettype wire

// ==== hw/csr_access.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_access (
    input  wire                   clk,
    input  csr_pkg::csr_addr_t    rd_addr,
    input  wire                   csr_wr_en,
    input  csr_pkg::csr_addr_t    wr_addr,
    input  csr_pkg::csr_word_t    wr_data,
    input  csr_pkg::csr_word_t    crmd,
    input  csr_pkg::csr_word_t    prmd,
    input  csr_pkg::csr_word_t    ectl,
    input  csr_pkg::csr_word_t    estat,
    input  csr_pkg::csr_word_t    era,
    input  csr_pkg::csr_word_t    badv,
    input  csr_pkg::csr_word_t    eentry,
    input  csr_pkg::csr_word_t    tcfg,
    input  csr_pkg::csr_word_t    tval,
    output csr_pkg::csr_word_t    rd_data,
    output logic                  crmd_wen,
    output logic                  prmd_wen,
    output logic                  ectl_wen,
    output logic                  estat_wen,
    output logic                  era_wen,
    output logic                  badv_wen,
    output logic                  eentry_wen,
    output logic                  tcfg_wen,
    output logic                  ticlr_wen
);

    import csr_pkg::*;

    localparam csr_addr_t SAVE_ADDR [`SAVE_COUNT] = '{
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3
    };

    csr_word_t save_q [`SAVE_COUNT];

    // one strobe per register, decoded only here
    assign crmd_wen   = csr_wr_en && (wr_addr == `CSR_CRMD);
    assign prmd_wen   = csr_wr_en && (wr_addr == `CSR_PRMD);
    assign ectl_wen   = csr_wr_en && (wr_addr == `CSR_ECTL);
    assign estat_wen  = csr_wr_en && (wr_addr == `CSR_ESTAT);
    assign era_wen    = csr_wr_en && (wr_addr == `CSR_ERA);
    assign badv_wen   = csr_wr_en && (wr_addr == `CSR_BADV);
    assign eentry_wen = csr_wr_en && (wr_addr == `CSR_EENTRY);
    assign tcfg_wen   = csr_wr_en && (wr_addr == `CSR_TCFG);
    assign ticlr_wen  = csr_wr_en && (wr_addr == `CSR_TICLR);

    // scratch registers for the exception handler
    for (genvar i = 0; i < `SAVE_COUNT; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (csr_wr_en && (wr_addr == SAVE_ADDR[i])) begin
                save_q[i] <= wr_data;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            `CSR_CRMD:   rd_data = crmd;
            `CSR_PRMD:   rd_data = prmd;
            `CSR_ECTL:   rd_data = ectl;
            `CSR_ESTAT:  rd_data = estat;
            `CSR_ERA:    rd_data = era;
            `CSR_BADV:   rd_data = badv;
            `CSR_EENTRY: rd_data = eentry;
            `CSR_TCFG:   rd_data = tcfg;
            `CSR_TVAL:   rd_data = tval;
            // clear strobe only
            `CSR_TICLR:  rd_data = '0;
            default: begin
                for (int i = 0; i < `SAVE_COUNT; i++) begin
                    if (rd_addr == SAVE_ADDR[i]) begin
                        rd_data = save_q[i];
                    end
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/csr_mode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_mode (
    input  wire                   clk,
    input  wire                   reset,
    input  csr_pkg::csr_word_t    wr_data,
    input  wire                   crmd_wen,
    input  wire                   prmd_wen,
    input  wire                   excp_flush,
    input  wire                   ertn_flush,
    output csr_pkg::csr_word_t    crmd,
    output csr_pkg::csr_word_t    prmd,
    output logic                  crmd_ie,
    output csr_pkg::plv_t         plv_out
);

    // crmd, reserved bits held at zero from reset
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= `CRMD_RESET;
        end else if (excp_flush) begin
            crmd[`CRMD_PLV] <= '0;
            crmd[`CRMD_IE]  <= 1'b0;
        end else if (ertn_flush) begin
            crmd[`CRMD_PLV] <= prmd[`PRMD_PPLV];
            crmd[`CRMD_IE]  <= prmd[`PRMD_PIE];
        end else if (crmd_wen) begin
            crmd[`CRMD_PLV]  <= wr_data[`CRMD_PLV];
            crmd[`CRMD_IE]   <= wr_data[`CRMD_IE];
            crmd[`CRMD_DA]   <= wr_data[`CRMD_DA];
            crmd[`CRMD_PG]   <= wr_data[`CRMD_PG];
            crmd[`CRMD_DATF] <= wr_data[`CRMD_DATF];
            crmd[`CRMD_DATM] <= wr_data[`CRMD_DATM];
        end
    end

    // prmd saves the interrupted context
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[`PRMD_PPLV] <= crmd[`CRMD_PLV];
            prmd[`PRMD_PIE]  <= crmd[`CRMD_IE];
        end else if (prmd_wen) begin
            prmd[`PRMD_PPLV] <= wr_data[`PRMD_PPLV];
            prmd[`PRMD_PIE]  <= wr_data[`PRMD_PIE];
        end
    end

    assign crmd_ie = crmd[`CRMD_IE];

    // level that crmd will hold after this edge
    always_comb begin
        if (excp_flush) begin
            plv_out = '0;
        end else if (ertn_flush) begin
            plv_out = prmd[`PRMD_PPLV];
        end else if (crmd_wen) begin
            plv_out = wr_data[`CRMD_PLV];
        end else begin
            plv_out = crmd[`CRMD_PLV];
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_exception.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_exception (
    input  wire                   clk,
    input  wire                   reset,
    input  csr_pkg::csr_word_t    wr_data,
    input  wire                   ectl_wen,
    input  wire                   estat_wen,
    input  wire                   era_wen,
    input  wire                   badv_wen,
    input  wire                   eentry_wen,
    input  wire [7:0]             interrupt,
    input  wire                   timer_pending,
    input  wire                   crmd_ie,
    input  wire                   excp_flush,
    input  csr_pkg::csr_word_t    era_in,
    input  csr_pkg::ecode_t       ecode_in,
    input  csr_pkg::esubcode_t    esubcode_in,
    input  wire                   va_error_in,
    input  csr_pkg::csr_word_t    bad_va_in,
    output csr_pkg::csr_word_t    ectl,
    output csr_pkg::csr_word_t    estat,
    output csr_pkg::csr_word_t    era,
    output csr_pkg::csr_word_t    badv,
    output csr_pkg::csr_word_t    eentry,
    output logic                  has_int,
    output csr_pkg::ecode_t       ecode_out
);

    import csr_pkg::*;

    logic [1:0]  sw_q;
    logic [7:0]  hw_q;
    logic [25:0] eentry_va;
    ecode_t      ecode_q;
    esubcode_t   esubcode_q;
    int_vec_t    int_status;

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl       <= '0;
            sw_q       <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            // lie bits 10 and 12 stay zero
            if (ectl_wen) begin
                ectl[`ECTL_LIE] <= wr_data[`ECTL_LIE] & `ECTL_LIE_WMASK;
            end
            if (estat_wen) begin
                sw_q <= wr_data[`IS_SW];
            end
            if (excp_flush) begin
                ecode_q    <= ecode_in;
                esubcode_q <= esubcode_in;
            end
        end
    end

    // hardware lines resampled every cycle
    always_ff @(posedge clk) begin
        hw_q <= interrupt;
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (era_wen) begin
            era <= wr_data;
        end
    end

    // software write wins over the faulting address
    always_ff @(posedge clk) begin
        if (badv_wen) begin
            badv <= wr_data;
        end else if (va_error_in) begin
            badv <= bad_va_in;
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_wen) begin
            eentry_va <= wr_data[`EENTRY_VA];
        end
    end

    always_comb begin
        int_status         = '0;
        int_status[`IS_SW] = sw_q;
        int_status[`IS_HW] = hw_q;
        int_status[`IS_TI] = timer_pending;
    end

    always_comb begin
        estat                  = '0;
        estat[`ESTAT_IS]       = int_status;
        estat[`ESTAT_ECODE]    = ecode_q;
        estat[`ESTAT_ESUBCODE] = esubcode_q;
    end

    always_comb begin
        eentry             = '0;
        eentry[`EENTRY_VA] = eentry_va;
    end

    assign has_int   = crmd_ie && ((ectl[`ECTL_LIE] & int_status) != '0);
    assign ecode_out = ecode_q;

endmodule

`default_nettype wire

// ==== hw/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_timer (
    input  wire                   clk,
    input  wire                   reset,
    input  csr_pkg::csr_word_t    wr_data,
    input  wire                   tcfg_wen,
    input  wire                   ticlr_wen,
    output csr_pkg::csr_word_t    tcfg,
    output csr_pkg::csr_word_t    tval,
    output logic                  timer_pending
);

    import csr_pkg::*;

    csr_word_t init_count;
    csr_word_t wr_count;
    logic      timer_en;
    logic      expire;

    // initval counts in units of four cycles
    assign init_count = {tcfg[`TCFG_INITVAL], {`TIMER_SHIFT{1'b0}}};
    assign wr_count   = {wr_data[`TCFG_INITVAL], {`TIMER_SHIFT{1'b0}}};
    assign expire     = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg[`TCFG_EN]       <= wr_data[`TCFG_EN];
            tcfg[`TCFG_PERIODIC] <= wr_data[`TCFG_PERIODIC];
            tcfg[`TCFG_INITVAL]  <= wr_data[`TCFG_INITVAL];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
            timer_en      <= 1'b0;
        end else if (ticlr_wen && wr_data[`TICLR_CLR]) begin
            timer_pending <= 1'b0;
        end else if (tcfg_wen) begin
            timer_en <= wr_data[`TCFG_EN];
        end else if (expire) begin
            timer_pending <= 1'b1;
            timer_en      <= tcfg[`TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '0;
        end else if (tcfg_wen) begin
            tval <= wr_count;
        end else if (expire) begin
            // one-shot wraps to all ones and stops
            tval <= tcfg[`TCFG_PERIODIC] ? init_count : '1;
        end else if (timer_en) begin
            tval <= tval - 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  wire                   clk,
    input  wire                   reset,
    input  csr_pkg::csr_addr_t    rd_addr,
    output csr_pkg::csr_word_t    rd_data,
    input  wire                   csr_wr_en,
    input  csr_pkg::csr_addr_t    wr_addr,
    input  csr_pkg::csr_word_t    wr_data,
    input  wire [7:0]             interrupt,
    output logic                  has_int,
    input  wire                   excp_flush,
    input  wire                   ertn_flush,
    input  csr_pkg::csr_word_t    era_in,
    input  csr_pkg::ecode_t       ecode_in,
    input  csr_pkg::esubcode_t    esubcode_in,
    input  wire                   va_error_in,
    input  csr_pkg::csr_word_t    bad_va_in,
    output csr_pkg::plv_t         plv_out,
    output csr_pkg::csr_word_t    eentry_out,
    output csr_pkg::csr_word_t    era_out,
    output csr_pkg::ecode_t       ecode_out
);

    import csr_pkg::*;

    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t ectl;
    csr_word_t estat;
    csr_word_t era;
    csr_word_t badv;
    csr_word_t eentry;
    csr_word_t tcfg;
    csr_word_t tval;

    logic crmd_wen;
    logic prmd_wen;
    logic ectl_wen;
    logic estat_wen;
    logic era_wen;
    logic badv_wen;
    logic eentry_wen;
    logic tcfg_wen;
    logic ticlr_wen;

    logic crmd_ie;
    logic timer_pending;

    csr_access i_csr_access (
        .clk        (clk),
        .rd_addr    (rd_addr),
        .csr_wr_en  (csr_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .crmd       (crmd),
        .prmd       (prmd),
        .ectl       (ectl),
        .estat      (estat),
        .era        (era),
        .badv       (badv),
        .eentry     (eentry),
        .tcfg       (tcfg),
        .tval       (tval),
        .rd_data    (rd_data),
        .crmd_wen   (crmd_wen),
        .prmd_wen   (prmd_wen),
        .ectl_wen   (ectl_wen),
        .estat_wen  (estat_wen),
        .era_wen    (era_wen),
        .badv_wen   (badv_wen),
        .eentry_wen (eentry_wen),
        .tcfg_wen   (tcfg_wen),
        .ticlr_wen  (ticlr_wen)
    );

    csr_mode i_csr_mode (
        .clk        (clk),
        .reset      (reset),
        .wr_data    (wr_data),
        .crmd_wen   (crmd_wen),
        .prmd_wen   (prmd_wen),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd),
        .prmd       (prmd),
        .crmd_ie    (crmd_ie),
        .plv_out    (plv_out)
    );

    csr_exception i_csr_exception (
        .clk           (clk),
        .reset         (reset),
        .wr_data       (wr_data),
        .ectl_wen      (ectl_wen),
        .estat_wen     (estat_wen),
        .era_wen       (era_wen),
        .badv_wen      (badv_wen),
        .eentry_wen    (eentry_wen),
        .interrupt     (interrupt),
        .timer_pending (timer_pending),
        .crmd_ie       (crmd_ie),
        .excp_flush    (excp_flush),
        .era_in        (era_in),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .va_error_in   (va_error_in),
        .bad_va_in     (bad_va_in),
        .ectl          (ectl),
        .estat         (estat),
        .era           (era),
        .badv          (badv),
        .eentry        (eentry),
        .has_int       (has_int),
        .ecode_out     (ecode_out)
    );

    csr_timer i_csr_timer (
        .clk           (clk),
        .reset         (reset),
        .wr_data       (wr_data),
        .tcfg_wen      (tcfg_wen),
        .ticlr_wen     (ticlr_wen),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

    // fetch redirect targets
    assign era_out    = era;
    assign eentry_out = eentry;

endmodule

`default_nettype wire

// ==== bench/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// writable bits per register
localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
localparam logic [31:0] ECTL_WMASK   = 32'h0000_0bff;
localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

logic [31:0] m_crmd;
logic [31:0] m_prmd;
logic [31:0] m_ectl;
logic [31:0] m_era;
logic [31:0] m_badv;
logic [31:0] m_eentry;
logic [31:0] m_tcfg;
logic [31:0] m_tval;
logic [31:0] m_save [4];
logic [1:0]  m_sw;
logic [7:0]  m_hw;
logic [5:0]  m_ecode;
logic [8:0]  m_esub;
logic        m_ten;
logic        m_pend;

function automatic logic write_hit(input logic [13:0] addr);
    return csr_wr_en && (wr_addr == addr);
endfunction

function automatic logic [31:0] predict_read(input logic [13:0] addr);
    logic [31:0] estat;
    estat = {1'b0, m_esub, m_ecode, 3'b000, 1'b0, m_pend, 1'b0, m_hw, m_sw};
    case (addr)
        `CSR_CRMD:   return m_crmd;
        `CSR_PRMD:   return m_prmd;
        `CSR_ECTL:   return m_ectl;
        `CSR_ESTAT:  return estat;
        `CSR_ERA:    return m_era;
        `CSR_BADV:   return m_badv;
        `CSR_EENTRY: return m_eentry;
        `CSR_SAVE0:  return m_save[0];
        `CSR_SAVE1:  return m_save[1];
        `CSR_SAVE2:  return m_save[2];
        `CSR_SAVE3:  return m_save[3];
        `CSR_TCFG:   return m_tcfg;
        `CSR_TVAL:   return m_tval;
        default:     return 32'h0;
    endcase
endfunction

function automatic logic predict_has_int();
    logic [31:0] estat;
    estat = predict_read(`CSR_ESTAT);
    return m_crmd[2] && ((m_ectl[12:0] & estat[12:0]) != 13'h0);
endfunction

// level after the coming edge
function automatic logic [1:0] predict_plv();
    if (excp_flush) return 2'b00;
    if (ertn_flush) return m_prmd[1:0];
    if (write_hit(`CSR_CRMD)) return wr_data[1:0];
    return m_crmd[1:0];
endfunction

// one clock edge, with the inputs of the cycle that ends there
task automatic step_model();
    logic [31:0] old_crmd;
    logic [31:0] old_tcfg;
    logic        expire;
    old_crmd = m_crmd;
    old_tcfg = m_tcfg;
    expire = m_ten && (m_tval == 32'h0);
    m_hw = interrupt;
    if (reset) begin
        m_crmd = 32'h0000_0008;
        m_prmd = 32'h0;
        m_ectl = 32'h0;
        m_sw = 2'b00;
        m_ecode = 6'h0;
        m_esub = 9'h0;
        m_tcfg = 32'h0;
        m_tval = 32'h0;
        m_ten = 1'b0;
        m_pend = 1'b0;
    end else begin
        if (excp_flush) begin
            m_crmd[2:0] = 3'b000;
            m_prmd[2:0] = old_crmd[2:0];
            m_ecode = ecode_in;
            m_esub = esubcode_in;
        end else begin
            if (ertn_flush) m_crmd[2:0] = m_prmd[2:0];
            else if (write_hit(`CSR_CRMD)) m_crmd = wr_data & CRMD_WMASK;
            if (write_hit(`CSR_PRMD)) m_prmd = wr_data & PRMD_WMASK;
        end
        if (write_hit(`CSR_ECTL)) m_ectl = wr_data & ECTL_WMASK;
        if (write_hit(`CSR_ESTAT)) m_sw = wr_data[1:0];
        // countdown uses the enable from before this edge
        if (write_hit(`CSR_TCFG)) m_tval = {wr_data[31:2], 2'b00};
        else if (expire) m_tval = old_tcfg[1] ? {old_tcfg[31:2], 2'b00} : 32'hffff_ffff;
        else if (m_ten) m_tval = m_tval - 32'd1;
        if (write_hit(`CSR_TICLR) && wr_data[0]) begin
            m_pend = 1'b0;
        end else if (write_hit(`CSR_TCFG)) begin
            m_ten = wr_data[0];
        end else if (expire) begin
            m_pend = 1'b1;
            m_ten = old_tcfg[1];
        end
        if (write_hit(`CSR_TCFG)) m_tcfg = wr_data;
    end
    if (excp_flush) m_era = era_in;
    else if (write_hit(`CSR_ERA)) m_era = wr_data;
    if (write_hit(`CSR_BADV)) m_badv = wr_data;
    else if (va_error_in) m_badv = bad_va_in;
    if (write_hit(`CSR_EENTRY)) m_eentry = wr_data & EENTRY_WMASK;
    for (int i = 0; i < 4; i++) begin
        if (write_hit(14'(`CSR_SAVE0 + i))) m_save[i] = wr_data;
    end
endtask

`endif

// ==== bench/csr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_tb;

    import csr_pkg::*;

    localparam int RESET_CYCLES     = 8;
    localparam int RW_OPS           = 400;
    localparam int EXCP_OPS         = 200;
    localparam int BADV_OPS         = 40;
    localparam int INT_OPS          = 200;
    localparam int TIMER_RUNS       = 8;
    localparam int TIMER_RUN_CYCLES = 80;
    localparam int PHASE_CYCLES     = RESET_CYCLES + 20 + 2 * RW_OPS + EXCP_OPS
                                    + 2 * BADV_OPS + INT_OPS + TIMER_RUNS * TIMER_RUN_CYCLES;
    localparam int CYCLE_LIMIT      = 2 * PHASE_CYCLES;

    // kept addresses followed by a few unmapped ones
    localparam csr_addr_t ADDR_POOL [19] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_ECTL, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR,
        14'h002, 14'h008, 14'h034, 14'h043, 14'h3fff
    };
    localparam csr_addr_t NORESET_ADDRS [7] = '{
        `CSR_ERA, `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3
    };
    localparam csr_addr_t EXCP_READS [4] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA};
    localparam csr_addr_t INT_WRITES [4] = '{`CSR_ECTL, `CSR_CRMD, `CSR_ESTAT, `CSR_ECTL};

    logic       clk = 1'b0;
    logic       reset;
    csr_addr_t  rd_addr;
    csr_word_t  rd_data;
    logic       csr_wr_en;
    csr_addr_t  wr_addr;
    csr_word_t  wr_data;
    logic [7:0] interrupt;
    logic       has_int;
    logic       excp_flush;
    logic       ertn_flush;
    csr_word_t  era_in;
    ecode_t     ecode_in;
    esubcode_t  esubcode_in;
    logic       va_error_in;
    csr_word_t  bad_va_in;
    plv_t       plv_out;
    csr_word_t  eentry_out;
    csr_word_t  era_out;
    ecode_t     ecode_out;

    int   checks = 0;
    int   mismatches = 0;
    int   failures = 0;
    int   cycle_count = 0;
    logic outputs_known = 1'b0;

    `include "csr_model.svh"

    csr_top i_csr_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) step_model();

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            failures++;
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            report_and_finish();
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // pulses default low and callers raise them afterwards
    task automatic drive(input logic wen, input csr_addr_t waddr, input csr_word_t wdata,
                         input csr_addr_t raddr);
        @(posedge clk);
        csr_wr_en   <= wen;
        wr_addr     <= waddr;
        wr_data     <= wdata;
        rd_addr     <= raddr;
        excp_flush  <= 1'b0;
        ertn_flush  <= 1'b0;
        va_error_in <= 1'b0;
    endtask

    task automatic check_cycle(input string name);
        @(negedge clk);
        check_value(name, predict_read(rd_addr), rd_data);
        check_value({name, " has_int"}, {31'b0, predict_has_int()}, {31'b0, has_int});
        check_value({name, " plv_out"}, {30'b0, predict_plv()}, {30'b0, plv_out});
        if (outputs_known) begin
            check_value({name, " era_out"}, m_era, era_out);
            check_value({name, " eentry_out"}, m_eentry, eentry_out);
            check_value({name, " ecode_out"}, {26'b0, m_ecode}, {26'b0, ecode_out});
        end
    endtask

    task automatic expect_read(input string name, input csr_addr_t addr,
                               input csr_word_t expected, input csr_word_t mask);
        drive(1'b0, '0, '0, addr);
        @(negedge clk);
        check_value(name, expected, rd_data & mask);
    endtask

    function automatic csr_addr_t pick_addr();
        int idx;
        idx = $urandom_range(0, 18);
        return ADDR_POOL[idx];
    endfunction

    initial begin
        int        init_val;
        int        periodic;
        int        edges;
        int        sel;
        csr_word_t data;
        csr_addr_t addr;
        reset = 1'b1;
        rd_addr = '0;
        csr_wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        interrupt = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        era_in = '0;
        ecode_in = '0;
        esubcode_in = '0;
        va_error_in = 1'b0;
        bad_va_in = '0;
        void'($urandom(32'hd638_8ee0));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        expect_read("reset crmd", `CSR_CRMD, 32'h0000_0008, '1);
        expect_read("reset prmd", `CSR_PRMD, 32'h0, '1);
        expect_read("reset ectl", `CSR_ECTL, 32'h0, '1);
        expect_read("reset estat", `CSR_ESTAT, 32'h0, '1);
        expect_read("reset eentry low bits", `CSR_EENTRY, 32'h0, 32'h0000_003f);
        expect_read("reset tcfg", `CSR_TCFG, 32'h0, '1);
        expect_read("reset tval", `CSR_TVAL, 32'h0, '1);
        expect_read("reset ticlr", `CSR_TICLR, 32'h0, '1);
        expect_read("reset unmapped", 14'h3fff, 32'h0, '1);
        check_value("reset has_int", 32'h0, {31'b0, has_int});
        check_value("reset plv_out", 32'h0, {30'b0, plv_out});

        // registers without reset get a first value
        for (int i = 0; i < 7; i++) begin
            drive(1'b1, NORESET_ADDRS[i], $urandom(), `CSR_CRMD);
        end
        @(negedge clk);
        outputs_known = 1'b1;

        for (int i = 0; i < RW_OPS; i++) begin
            addr = pick_addr();
            drive(1'b1, addr, $urandom(), pick_addr());
            check_cycle("rw write");
            drive(1'b0, '0, '0, addr);
            check_cycle("rw readback");
        end

        for (int i = 0; i < EXCP_OPS; i++) begin
            sel = $urandom_range(0, 7);
            addr = (sel inside {1, 4}) ? `CSR_PRMD : `CSR_CRMD;
            drive(sel inside {1, 3, 4, 5, 6}, addr, $urandom(), EXCP_READS[i % 4]);
            excp_flush  <= sel inside {0, 1, 5};
            ertn_flush  <= sel inside {2, 5, 6};
            era_in      <= $urandom();
            ecode_in    <= ecode_t'($urandom());
            esubcode_in <= esubcode_t'($urandom());
            check_cycle("exception");
        end

        for (int i = 0; i < BADV_OPS; i++) begin
            data = $urandom();
            sel = $urandom_range(0, 1);
            drive(sel == 1, `CSR_BADV, data, `CSR_BADV);
            va_error_in <= 1'b1;
            bad_va_in   <= $urandom();
            check_cycle("badv strobe");
            drive(1'b0, '0, '0, `CSR_BADV);
            check_cycle("badv readback");
            if (sel == 1) check_value("badv priority", data, rd_data);
        end

        // timer stopped and pending cleared so only the lines and masks matter
        drive(1'b1, `CSR_TCFG, '0, `CSR_ESTAT);
        check_cycle("interrupt setup");
        drive(1'b1, `CSR_TICLR, 32'h1, `CSR_ESTAT);
        check_cycle("interrupt setup");
        for (int i = 0; i < INT_OPS; i++) begin
            sel = $urandom_range(0, 3);
            drive(sel != 3, INT_WRITES[sel], $urandom(), `CSR_ESTAT);
            interrupt <= 8'($urandom()) & 8'($urandom());
            check_cycle("interrupt mask");
        end

        for (int run = 0; run < TIMER_RUNS; run++) begin
            init_val = $urandom_range(0, 7);
            periodic = $urandom_range(0, 1);
            drive(1'b1, `CSR_TICLR, 32'h1, `CSR_ESTAT);
            interrupt <= '0;
            check_cycle("timer clear");
            drive(1'b1, `CSR_TCFG, {init_val[29:0], periodic[0], 1'b1}, `CSR_TVAL);
            check_cycle("timer start");
            edges = 0;
            do begin
                drive(1'b0, '0, '0, `CSR_ESTAT);
                edges++;
                check_cycle("timer countdown");
            end while (!rd_data[11] && edges < 64);
            if (!rd_data[11]) begin
                failures++;
                $display("Timer pending bit never came up in run %0d", run);
            end
            check_value("timer expiry edge", init_val * 4 + 2, edges);
            drive(1'b1, `CSR_TICLR, 32'h1, `CSR_ESTAT);
            check_cycle("timer ticlr");
            drive(1'b0, '0, '0, `CSR_ESTAT);
            check_cycle("timer cleared");
            check_value("timer pending cleared", 32'h0, {31'b0, rd_data[11]});
            repeat (init_val * 4 + 4) begin
                drive(1'b0, '0, '0, `CSR_TVAL);
                check_cycle("timer tval");
            end
            drive(1'b0, '0, '0, `CSR_ESTAT);
            check_cycle("timer rearm");
            check_value("timer rearm", periodic, {31'b0, rd_data[11]});
            drive(1'b1, `CSR_TCFG, '0, `CSR_TVAL);
            check_cycle("timer stop");
        end

        drive(1'b0, '0, '0, `CSR_CRMD);
        check_cycle("idle");
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
+incdir+bench
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_mode.sv
hw/csr_exception.sv
hw/csr_timer.sv
hw/csr_top.sv
bench/csr_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module csr_tb -Mdir obj_dir
	./obj_dir/Vcsr_tb > sim.log 2>&1; cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
